// File: hw/isaPkg.sv
package isaPkg;

    typedef logic [5:0] opcode_t;               // Primary opcode field
    typedef logic [5:0] funct_t;                // R-type function field

    //////////////////////////////////////////////////////////////////////
    // Opcode encodings
    localparam opcode_t opRType = 6'h00;
    localparam opcode_t opJ     = 6'h02;
    localparam opcode_t opJal   = 6'h03;
    localparam opcode_t opBeq   = 6'h04;
    localparam opcode_t opBne   = 6'h05;
    localparam opcode_t opBle   = 6'h06;
    localparam opcode_t opBgt   = 6'h07;
    localparam opcode_t opAddi  = 6'h08;
    localparam opcode_t opAddiu = 6'h09;
    localparam opcode_t opSlti  = 6'h0a;
    localparam opcode_t opLw    = 6'h23;
    localparam opcode_t opSw    = 6'h2b;

    //////////////////////////////////////////////////////////////////////
    // Funct encodings, valid only with opRType
    localparam funct_t fnJr  = 6'h08;
    localparam funct_t fnAdd = 6'h20;
    localparam funct_t fnSub = 6'h22;
    localparam funct_t fnAnd = 6'h24;
    localparam funct_t fnOr  = 6'h25;
    localparam funct_t fnSlt = 6'h2a;

    // One kind per supported instruction
    typedef enum logic [4:0] {
        kindAdd, kindSub, kindAnd, kindOr, kindSlt, kindJr,
        kindAddi, kindAddiu, kindSlti,
        kindBeq, kindBne, kindBle, kindBgt,
        kindLw, kindSw,
        kindJ, kindJal,
        kindInvalid
    } instrKind_e;

endpackage

// File: hw/controlPkg.sv
package controlPkg;

    //////////////////////////////////////////////////////////////////////
    // Sequencer states
    typedef enum logic [5:0] {
        resetInit, fetchWait, fetchLatch, decode,
        execAdd, execSub, execAnd, execOr, execSlt, writeRd,
        jumpReg, savePc,
        execAddi, execAddiu, execSlti, writeRt,
        branchTarget, cmpBeq, cmpBne, cmpBle, cmpBgt, branchCommit,
        addrCalc, memRead, loadWrite, storeWrite,
        jump, jumpLink,
        invalidTrap, overflowTrap, exceptionJump
    } state_e;

    //////////////////////////////////////////////////////////////////////
    // ALU control codes, numbering fixed by the ALU
    typedef enum logic [4:0] {
        aluPass = 5'd0,                         // S = A
        aluAdd  = 5'd1,                         // Add, flags overflow
        aluSub  = 5'd2,
        aluAnd  = 5'd3,
        aluCmp  = 5'd7,                         // Set on less than
        aluOr   = 5'd8,
        aluAddU = 5'd11,                        // Add, no overflow
        aluNe   = 5'd14,
        aluEq   = 5'd15,
        aluLe   = 5'd16,
        aluGt   = 5'd17
    } aluOp_e;

    //////////////////////////////////////////////////////////////////////
    // Datapath mux selects
    typedef enum logic [2:0] {
        srcBRegB         = 3'd0,
        srcBConstFour    = 3'd1,
        srcBImmediate    = 3'd2,
        srcBBranchOffset = 3'd3                 // Sign extended, shifted by 2
    } aluSrcB_e;

    typedef enum logic [2:0] {
        pcJumpTarget      = 3'd0,
        pcAluResult       = 3'd1,
        pcAluOut          = 3'd2,
        pcExceptionVector = 3'd3
    } pcSource_e;

    typedef enum logic [1:0] {
        destRt        = 2'd0,
        destRd        = 2'd1,
        destReturnReg = 2'd2,                   // $31
        destStackPtr  = 2'd3                    // $29
    } regDest_e;

    typedef enum logic [2:0] {
        wbAluOut        = 3'd0,
        wbMemData       = 3'd1,
        wbStackInit     = 3'd2,                 // Initial stack pointer constant
        wbExceptionData = 3'd3,
        wbReturnAddr    = 3'd4
    } memToReg_e;

    typedef enum logic [2:0] {
        addrPcOrAlu        = 3'd0,
        addrOverflowVector = 3'd1,
        addrInvalidVector  = 3'd3
    } srcAddr_e;

endpackage

// File: hw/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder
    import isaPkg::*;
(
    input  opcode_t    opcode,
    input  funct_t     funct,
    output instrKind_e instrKind
);

    instrKind_e rKind;                          // Kind when opcode is R-type

    //////////////////////////////////////////////////////////////////////
    // R-type function lookup
    always_comb
    begin
        case (funct)
            fnAdd:   rKind = kindAdd;
            fnSub:   rKind = kindSub;
            fnAnd:   rKind = kindAnd;
            fnOr:    rKind = kindOr;
            fnSlt:   rKind = kindSlt;
            fnJr:    rKind = kindJr;
            default: rKind = kindInvalid;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Primary opcode lookup
    always_comb
    begin
        case (opcode)
            opRType: instrKind = rKind;
            opAddi:  instrKind = kindAddi;
            opAddiu: instrKind = kindAddiu;
            opSlti:  instrKind = kindSlti;
            opBeq:   instrKind = kindBeq;
            opBne:   instrKind = kindBne;
            opBle:   instrKind = kindBle;
            opBgt:   instrKind = kindBgt;
            opLw:    instrKind = kindLw;
            opSw:    instrKind = kindSw;
            opJ:     instrKind = kindJ;
            opJal:   instrKind = kindJal;
            default: instrKind = kindInvalid;   // Unlisted opcodes trap
        endcase
    end

endmodule

// File: hw/controlSequencer.sv
`timescale 1ns/1ns

module controlSequencer
    import isaPkg::*, controlPkg::*;
#(
    parameter int MemWaitCycles = 2
)
(
    input  logic       clk,
    input  logic       reset,
    input  instrKind_e instrKind,
    input  logic       overflowFlag,
    output state_e     state
);

    localparam int CountWidth = (MemWaitCycles > 1) ? $clog2(MemWaitCycles) : 1;
    localparam logic [CountWidth-1:0] WaitLoad = CountWidth'(MemWaitCycles - 1);

    state_e                nextState;
    logic [CountWidth-1:0] waitCount;           // Cycles left in a wait state
    logic [CountWidth-1:0] nextCount;
    logic                  overflowExempt;

    // No overflow redirect out of reset or while already trapping
    assign overflowExempt = (state == resetInit) || (state == invalidTrap) ||
                            (state == overflowTrap) || (state == exceptionJump);

    //////////////////////////////////////////////////////////////////////
    // Next state
    always_comb
    begin
        nextState = fetchWait;
        case (state)
            resetInit:  nextState = fetchWait;
            fetchWait:  nextState = (waitCount == '0) ? fetchLatch : fetchWait;
            fetchLatch: nextState = decode;
            decode:
            begin
                case (instrKind)
                    kindAdd:   nextState = execAdd;
                    kindSub:   nextState = execSub;
                    kindAnd:   nextState = execAnd;
                    kindOr:    nextState = execOr;
                    kindSlt:   nextState = execSlt;
                    kindJr:    nextState = jumpReg;
                    kindAddi:  nextState = execAddi;
                    kindAddiu: nextState = execAddiu;
                    kindSlti:  nextState = execSlti;
                    kindBeq, kindBne, kindBle, kindBgt:
                               nextState = branchTarget;
                    kindLw, kindSw:
                               nextState = addrCalc;
                    kindJ:     nextState = jump;
                    kindJal:   nextState = jumpLink;
                    default:   nextState = invalidTrap;
                endcase
            end
            execAdd, execSub, execAnd, execOr, execSlt:
                nextState = writeRd;
            execAddi, execAddiu, execSlti:
                nextState = writeRt;
            jumpReg:      nextState = savePc;
            branchTarget:
            begin
                case (instrKind)
                    kindBne: nextState = cmpBne;
                    kindBle: nextState = cmpBle;
                    kindBgt: nextState = cmpBgt;
                    default: nextState = cmpBeq;
                endcase
            end
            cmpBeq, cmpBne, cmpBle, cmpBgt:
                nextState = branchCommit;
            addrCalc:     nextState = (instrKind == kindSw) ? storeWrite : memRead;
            memRead:      nextState = (waitCount == '0) ? loadWrite : memRead;
            invalidTrap:  nextState = exceptionJump;
            overflowTrap: nextState = exceptionJump;
            default:      nextState = fetchWait;    // Last step of every instruction
        endcase

        if (overflowFlag && !overflowExempt)
        begin
            nextState = overflowTrap;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Memory wait counter, loaded on entry to fetchWait or memRead
    always_comb
    begin
        nextCount = '0;
        if (nextState == fetchWait || nextState == memRead)
        begin
            if (nextState != state)
                nextCount = WaitLoad;
            else
                nextCount = waitCount - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= resetInit;
            waitCount <= '0;
        end
        else
        begin
            state     <= nextState;
            waitCount <= nextCount;
        end
    end

endmodule

// File: hw/controlSignalDecoder.sv
`timescale 1ns/1ns

module controlSignalDecoder
    import controlPkg::*;
(
    input  state_e    state,
    output logic      pcWriteCond,
    output logic      pcWrite,
    output logic      iorD,
    output logic      memWrite,
    output logic      irWrite,
    output logic      regWrite,
    output logic      aluSrcA,
    output srcAddr_e  srcAddr,
    output memToReg_e memToReg,
    output regDest_e  regDest,
    output aluSrcB_e  aluSrcB,
    output aluOp_e    aluOp,
    output pcSource_e pcSource
);

    always_comb
    begin
        //////////////////////////////////////////////////////////////////
        // Inactive defaults
        pcWriteCond = 1'b0;
        pcWrite     = 1'b0;
        iorD        = 1'b0;                     // Address from PC
        memWrite    = 1'b0;
        irWrite     = 1'b0;
        regWrite    = 1'b0;
        aluSrcA     = 1'b0;                     // A operand is PC
        srcAddr     = addrPcOrAlu;
        memToReg    = wbAluOut;
        regDest     = destRt;
        aluSrcB     = srcBRegB;
        aluOp       = aluPass;
        pcSource    = pcAluOut;

        //////////////////////////////////////////////////////////////////
        // Per-state overrides
        case (state)
            resetInit:
            begin
                regWrite = 1'b1;                // Load $29 with its start value
                regDest  = destStackPtr;
                memToReg = wbStackInit;
                pcSource = pcJumpTarget;        // All selects at zero here
            end
            fetchLatch:
            begin
                aluSrcB = srcBConstFour;        // PC + 4
                aluOp   = aluAdd;
                irWrite = 1'b1;
            end
            decode:       pcWrite = 1'b1;       // Commit PC + 4 from aluOut

            execAdd, execSub, execAnd, execOr, execSlt:
            begin
                aluSrcA = 1'b1;
                aluSrcB = srcBRegB;
                case (state)
                    execAdd: aluOp = aluAdd;
                    execSub: aluOp = aluSub;
                    execAnd: aluOp = aluAnd;
                    execOr:  aluOp = aluOr;
                    default: aluOp = aluCmp;
                endcase
            end
            writeRd:
            begin
                regWrite = 1'b1;
                regDest  = destRd;
            end

            jumpReg:
            begin
                aluSrcA  = 1'b1;                // Pass rs straight through
                pcSource = pcAluResult;
                pcWrite  = 1'b1;
            end
            savePc:
            begin
                pcSource = pcAluResult;
                pcWrite  = 1'b1;
            end

            execAddi, execAddiu, execSlti:
            begin
                aluSrcA = 1'b1;
                aluSrcB = srcBImmediate;
                case (state)
                    execAddi:  aluOp = aluAdd;
                    execAddiu: aluOp = aluAddU;
                    default:   aluOp = aluCmp;
                endcase
            end
            writeRt:      regWrite = 1'b1;

            branchTarget:
            begin
                aluSrcB = srcBBranchOffset;     // Target lands in aluOut
                aluOp   = aluAdd;
            end
            cmpBeq, cmpBne, cmpBle, cmpBgt:
            begin
                aluSrcA     = 1'b1;
                pcWriteCond = 1'b1;             // Taken only if compare is true
                case (state)
                    cmpBeq:  aluOp = aluEq;
                    cmpBne:  aluOp = aluNe;
                    cmpBle:  aluOp = aluLe;
                    default: aluOp = aluGt;
                endcase
            end
            branchCommit: aluSrcA = 1'b1;

            addrCalc, memRead, storeWrite:
            begin
                aluSrcA  = 1'b1;                // Base plus offset held on the ALU
                aluSrcB  = srcBImmediate;
                aluOp    = aluAdd;
                iorD     = (state != addrCalc);
                memWrite = (state == storeWrite);
            end
            loadWrite:
            begin
                iorD     = 1'b1;
                regWrite = 1'b1;
                memToReg = wbMemData;
            end

            jump, jumpLink:
            begin
                pcSource = pcJumpTarget;
                pcWrite  = 1'b1;
                if (state == jumpLink)
                begin
                    regWrite = 1'b1;            // Link into $31
                    regDest  = destReturnReg;
                    memToReg = wbReturnAddr;
                end
            end

            invalidTrap, overflowTrap, exceptionJump:
            begin
                memToReg = wbExceptionData;
                regDest  = destStackPtr;
                pcSource = pcExceptionVector;
                case (state)
                    invalidTrap:  srcAddr = addrInvalidVector;
                    overflowTrap: srcAddr = addrOverflowVector;
                    default:      pcWrite = 1'b1;   // Handler address into PC
                endcase
            end

            default: ;                          // fetchWait keeps the defaults
        endcase
    end

endmodule

// File: hw/controlUnit.sv
`timescale 1ns/1ns

module controlUnit
    import isaPkg::*, controlPkg::*;
#(
    parameter int MemWaitCycles = 2
)
(
    input  logic      clk,
    input  logic      reset,
    input  opcode_t   opcode,
    input  funct_t    funct,
    input  logic      overflowFlag,
    output logic      pcWriteCond,
    output logic      pcWrite,
    output logic      iorD,
    output logic      memWrite,
    output logic      irWrite,
    output logic      regWrite,
    output logic      aluSrcA,
    output srcAddr_e  srcAddr,
    output memToReg_e memToReg,
    output regDest_e  regDest,
    output aluSrcB_e  aluSrcB,
    output aluOp_e    aluOp,
    output pcSource_e pcSource
);

    instrKind_e instrKind;
    state_e     state;

    instrDecoder uInstrDecoder (
        .opcode    (opcode),
        .funct     (funct),
        .instrKind (instrKind)
    );

    controlSequencer #(
        .MemWaitCycles (MemWaitCycles)
    ) uControlSequencer (
        .clk          (clk),
        .reset        (reset),
        .instrKind    (instrKind),
        .overflowFlag (overflowFlag),
        .state        (state)
    );

    controlSignalDecoder uControlSignalDecoder (
        .state       (state),
        .pcWriteCond (pcWriteCond),
        .pcWrite     (pcWrite),
        .iorD        (iorD),
        .memWrite    (memWrite),
        .irWrite     (irWrite),
        .regWrite    (regWrite),
        .aluSrcA     (aluSrcA),
        .srcAddr     (srcAddr),
        .memToReg    (memToReg),
        .regDest     (regDest),
        .aluSrcB     (aluSrcB),
        .aluOp       (aluOp),
        .pcSource    (pcSource)
    );

endmodule

// File: dv/controlModel.svh
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// Expected state walk

function automatic logic isExecState(state_e s);
    return s inside {execAdd, execSub, execAnd, execOr, execSlt,
                     execAddi, execAddiu, execSlti};
endfunction

// First state after decode for an opcode and funct pair
function automatic state_e decodeTarget(opcode_t op, funct_t fn);
    case (op)
        opRType:
        begin
            case (fn)
                fnAdd:   return execAdd;
                fnSub:   return execSub;
                fnAnd:   return execAnd;
                fnOr:    return execOr;
                fnSlt:   return execSlt;
                fnJr:    return jumpReg;
                default: return invalidTrap;
            endcase
        end
        opAddi:  return execAddi;
        opAddiu: return execAddiu;
        opSlti:  return execSlti;
        opBeq, opBne, opBle, opBgt:
                 return branchTarget;
        opLw, opSw:
                 return addrCalc;
        opJ:     return jump;
        opJal:   return jumpLink;
        default: return invalidTrap;
    endcase
endfunction

// stay counts the cycles already spent in s before this one
function automatic state_e modelNext(state_e s, opcode_t op, funct_t fn, logic ovf, int stay);
    state_e n;
    case (s)
        fetchWait:  n = (stay + 1 >= MemWaitCycles) ? fetchLatch : fetchWait;
        fetchLatch: n = decode;
        decode:     n = decodeTarget(op, fn);
        execAdd, execSub, execAnd, execOr, execSlt:
                    n = writeRd;
        execAddi, execAddiu, execSlti:
                    n = writeRt;
        jumpReg:    n = savePc;
        branchTarget:
            n = (op == opBne) ? cmpBne : (op == opBle) ? cmpBle :
                (op == opBgt) ? cmpBgt : cmpBeq;
        cmpBeq, cmpBne, cmpBle, cmpBgt:
                    n = branchCommit;
        addrCalc:   n = (op == opSw) ? storeWrite : memRead;
        memRead:    n = (stay + 1 >= MemWaitCycles) ? loadWrite : memRead;
        invalidTrap, overflowTrap:
                    n = exceptionJump;
        default:    n = fetchWait;          // Final step of an instruction
    endcase
    if (ovf && !(s inside {resetInit, invalidTrap, overflowTrap, exceptionJump}))
        n = overflowTrap;
    return n;
endfunction

//////////////////////////////////////////////////////////////////////
// Expected control word, one field at a time

// {pcWriteCond, pcWrite, iorD, memWrite, irWrite, regWrite, aluSrcA}
function automatic logic [6:0] expStrobes(state_e s);
    logic [6:0] b;
    b[6] = s inside {cmpBeq, cmpBne, cmpBle, cmpBgt};
    b[5] = s inside {decode, jumpReg, savePc, jump, jumpLink, exceptionJump};
    b[4] = s inside {memRead, storeWrite, loadWrite};
    b[3] = (s == storeWrite);
    b[2] = (s == fetchLatch);
    b[1] = s inside {resetInit, writeRd, writeRt, loadWrite, jumpLink};
    b[0] = s inside {execAdd, execSub, execAnd, execOr, execSlt, jumpReg,
                     execAddi, execAddiu, execSlti, cmpBeq, cmpBne, cmpBle, cmpBgt,
                     branchCommit, addrCalc, memRead, storeWrite};
    return b;
endfunction

function automatic aluOp_e expAluOp(state_e s);
    case (s)
        fetchLatch, branchTarget, execAdd, execAddi, addrCalc, memRead, storeWrite:
                           return aluAdd;
        execSub:           return aluSub;
        execAnd:           return aluAnd;
        execOr:            return aluOr;
        execSlt, execSlti: return aluCmp;
        execAddiu:         return aluAddU;
        cmpBeq:            return aluEq;
        cmpBne:            return aluNe;
        cmpBle:            return aluLe;
        cmpBgt:            return aluGt;
        default:           return aluPass;
    endcase
endfunction

function automatic aluSrcB_e expAluSrcB(state_e s);
    if (s == fetchLatch)
        return srcBConstFour;
    if (s == branchTarget)
        return srcBBranchOffset;
    if (s inside {execAddi, execAddiu, execSlti, addrCalc, memRead, storeWrite})
        return srcBImmediate;
    return srcBRegB;
endfunction

function automatic pcSource_e expPcSource(state_e s);
    if (s inside {resetInit, jump, jumpLink})
        return pcJumpTarget;
    if (s inside {jumpReg, savePc})
        return pcAluResult;
    if (s inside {invalidTrap, overflowTrap, exceptionJump})
        return pcExceptionVector;
    return pcAluOut;
endfunction

function automatic regDest_e expRegDest(state_e s);
    if (s inside {resetInit, invalidTrap, overflowTrap, exceptionJump})
        return destStackPtr;
    if (s == writeRd)
        return destRd;
    if (s == jumpLink)
        return destReturnReg;
    return destRt;
endfunction

function automatic memToReg_e expMemToReg(state_e s);
    case (s)
        resetInit: return wbStackInit;
        loadWrite: return wbMemData;
        jumpLink:  return wbReturnAddr;
        invalidTrap, overflowTrap, exceptionJump:
                   return wbExceptionData;
        default:   return wbAluOut;
    endcase
endfunction

function automatic srcAddr_e expSrcAddr(state_e s);
    if (s == invalidTrap)
        return addrInvalidVector;
    if (s == overflowTrap)
        return addrOverflowVector;
    return addrPcOrAlu;
endfunction

`endif

// File: dv/controlUnitTb.sv
`timescale 1ns/1ns

module controlUnitTb
    import isaPkg::*, controlPkg::*;
();

    localparam int MemWaitCycles = 2;
    localparam int ClkPeriod     = 100;
    localparam int NumTests      = 300;
    localparam int ValidCount    = 17;
    localparam int LongestInstr  = 2 * MemWaitCycles + 5;   // Fetch, decode, lw tail, slack
    localparam int TimeoutCycles = 16 + 2 + (NumTests + 1) * LongestInstr + 100;

    logic      clk;
    logic      reset;
    opcode_t   opcode;
    funct_t    funct;
    logic      overflowFlag;
    logic      pcWriteCond, pcWrite, iorD, memWrite, irWrite, regWrite, aluSrcA;
    srcAddr_e  srcAddr;
    memToReg_e memToReg;
    regDest_e  regDest;
    aluSrcB_e  aluSrcB;
    aluOp_e    aluOp;
    pcSource_e pcSource;

    state_e      modelState;
    int          stayCount;                 // Cycles already spent in modelState
    logic [31:0] lcgState;
    int          testErrors, totalErrors, passCount, failCount, overflowHits;
    logic        testOverflow;

    opcode_t validOp [ValidCount] = '{opRType, opRType, opRType, opRType, opRType, opRType,
        opAddi, opAddiu, opSlti, opBeq, opBne, opBle, opBgt, opLw, opSw, opJ, opJal};
    funct_t  validFn [6] = '{fnAdd, fnSub, fnAnd, fnOr, fnSlt, fnJr};

    `include "controlModel.svh"

    controlUnit #(
        .MemWaitCycles (MemWaitCycles)
    ) DUT (
        .clk          (clk),
        .reset        (reset),
        .opcode       (opcode),
        .funct        (funct),
        .overflowFlag (overflowFlag),
        .pcWriteCond  (pcWriteCond),
        .pcWrite      (pcWrite),
        .iorD         (iorD),
        .memWrite     (memWrite),
        .irWrite      (irWrite),
        .regWrite     (regWrite),
        .aluSrcA      (aluSrcA),
        .srcAddr      (srcAddr),
        .memToReg     (memToReg),
        .regDest      (regDest),
        .aluSrcB      (aluSrcB),
        .aluOp        (aluOp),
        .pcSource     (pcSource)
    );

    initial
    begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial
    begin
        #(TimeoutCycles * ClkPeriod);
        $display("Watchdog expired after %0d cycles, the run did not finish", TimeoutCycles);
        $display("Some tests failed");
        $finish;
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    task automatic checkBit(string name, logic exp, logic act);
        if (act !== exp)
        begin
            $display("** Error at %0t ns: %s expected %b, actual %b", $time, name, exp, act);
            testErrors++;
        end
    endtask

    task automatic checkAluOp(string name, aluOp_e exp, aluOp_e act);
        if (act !== exp)
        begin
            $display("** Error at %0t ns: %s expected %s (%0d), actual %s (%0d)",
                     $time, name, exp.name(), exp, act.name(), act);
            testErrors++;
        end
    endtask

    task automatic checkAluSrcB(string name, aluSrcB_e exp, aluSrcB_e act);
        if (act !== exp)
        begin
            $display("** Error at %0t ns: %s expected %s (%0d), actual %s (%0d)",
                     $time, name, exp.name(), exp, act.name(), act);
            testErrors++;
        end
    endtask

    task automatic checkPcSource(string name, pcSource_e exp, pcSource_e act);
        if (act !== exp)
        begin
            $display("** Error at %0t ns: %s expected %s (%0d), actual %s (%0d)",
                     $time, name, exp.name(), exp, act.name(), act);
            testErrors++;
        end
    endtask

    task automatic checkRegDest(string name, regDest_e exp, regDest_e act);
        if (act !== exp)
        begin
            $display("** Error at %0t ns: %s expected %s (%0d), actual %s (%0d)",
                     $time, name, exp.name(), exp, act.name(), act);
            testErrors++;
        end
    endtask

    task automatic checkMemToReg(string name, memToReg_e exp, memToReg_e act);
        if (act !== exp)
        begin
            $display("** Error at %0t ns: %s expected %s (%0d), actual %s (%0d)",
                     $time, name, exp.name(), exp, act.name(), act);
            testErrors++;
        end
    endtask

    task automatic checkSrcAddr(string name, srcAddr_e exp, srcAddr_e act);
        if (act !== exp)
        begin
            $display("** Error at %0t ns: %s expected %s (%0d), actual %s (%0d)",
                     $time, name, exp.name(), exp, act.name(), act);
            testErrors++;
        end
    endtask

    task automatic checkOutputs();
        logic [6:0] strobes;
        strobes = expStrobes(modelState);
        checkBit("pcWriteCond", strobes[6], pcWriteCond);
        checkBit("pcWrite", strobes[5], pcWrite);
        checkBit("iorD", strobes[4], iorD);
        checkBit("memWrite", strobes[3], memWrite);
        checkBit("irWrite", strobes[2], irWrite);
        checkBit("regWrite", strobes[1], regWrite);
        checkBit("aluSrcA", strobes[0], aluSrcA);
        checkAluOp("aluOp", expAluOp(modelState), aluOp);
        checkAluSrcB("aluSrcB", expAluSrcB(modelState), aluSrcB);
        checkPcSource("pcSource", expPcSource(modelState), pcSource);
        checkRegDest("regDest", expRegDest(modelState), regDest);
        checkMemToReg("memToReg", expMemToReg(modelState), memToReg);
        checkSrcAddr("srcAddr", expSrcAddr(modelState), srcAddr);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    task automatic pickInstruction();
        logic [31:0] r;
        int          idx;
        r = nextRandom();
        if (r[31:29] == 3'b000)             // Raw encoding that is mostly invalid
        begin
            opcode = r[5:0];
            funct  = r[11:6];
        end
        else
        begin
            idx    = int'(r[23:8]) % ValidCount;
            opcode = validOp[idx];
            if (idx < 6)
                funct = validFn[idx];
            else
                funct = r[5:0];             // Ignored outside R-type
        end
    endtask

    task automatic driveInputs();
        overflowFlag = 1'b0;
        if (modelState == fetchWait && stayCount == 0)
            pickInstruction();
        else if ((isExecState(modelState) ||
                  modelState inside {invalidTrap, overflowTrap, exceptionJump}) &&
                 (nextRandom() >> 24) < 32'd40)
        begin
            overflowFlag = 1'b1;            // Traps in exec, ignored while trapping
            testOverflow = 1'b1;
            overflowHits++;
        end
    endtask

    // Check on the falling edge and step the model on the rising edge
    task automatic runCycle();
        state_e next;
        @(negedge clk);
        checkOutputs();
        @(posedge clk);
        next       = modelNext(modelState, opcode, funct, overflowFlag, stayCount);
        stayCount  = (next == modelState) ? stayCount + 1 : 0;
        modelState = next;
        #5;
        driveInputs();
    endtask

    task automatic reportTest(int num, string label);
        totalErrors += testErrors;
        if (testErrors == 0)
            passCount++;
        else
            failCount++;
        $display("Test %0d %s: %s, %0d mismatches", num, label,
                 (testErrors == 0) ? "pass" : "FAIL", testErrors);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    initial
    begin
        reset        = 1'b1;
        opcode       = opRType;
        funct        = fnAdd;
        overflowFlag = 1'b0;
        lcgState     = 32'h80e05db3;
        totalErrors  = 0;
        passCount    = 0;
        failCount    = 0;
        overflowHits = 0;
        repeat (16) @(posedge clk);
        #5;
        reset        = 1'b0;
        overflowFlag = 1'b1;                // resetInit must ignore it
        modelState   = resetInit;
        stayCount    = 0;

        testErrors = 0;
        runCycle();                         // resetInit then the first fetch entry
        reportTest(0, "reset init");

        for (int t = 1; t <= NumTests; t++)
        begin
            string label;
            label        = $sformatf("opcode %h funct %h", opcode, funct);
            testErrors   = 0;
            testOverflow = 1'b0;
            do
                runCycle();
            while (!(modelState == fetchWait && stayCount == 0));
            if (testOverflow)
                label = {label, " with overflow"};
            reportTest(t, label);
        end

        $display("%0d tests, %0d passed, %0d failed, %0d mismatches, %0d overflow injections",
                 NumTests + 1, passCount, failCount, totalErrors, overflowHits);
        if (failCount == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// File: build.f
+incdir+dv
hw/isaPkg.sv
hw/controlPkg.sv
hw/instrDecoder.sv
hw/controlSequencer.sv
hw/controlSignalDecoder.sv
hw/controlUnit.sv
dv/controlUnitTb.sv

// File: runSim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
    verilator --binary --timing --top-module controlUnitTb -f build.f &&
    ./obj_dir/VcontrolUnitTb | tee /dev/stderr | grep -q "All tests passed" &&
    echo "Simulation PASSED" ||
    { echo "Simulation FAILED"; exit 1; }
